/* bell_game_top.sv */
module bell_game_top import bell_pkg::*; #(
    parameter int score_w    = 10,
    parameter int win_margin = 50
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [key_w-1:0]          keypad_in,
    input  logic                      new_round,
    input  logic [color_w-1:0]        c1,
    input  logic [color_w-1:0]        c2,
    input  logic [num_w-1:0]          n1,
    input  logic [num_w-1:0]          n2,
    input  logic [pile_w-1:0]         pile_count,
    output logic                      locked,
    output logic signed [score_w-1:0] score_a,
    output logic signed [score_w-1:0] score_b,
    output player_t                   winner
);

    logic    claim;
    player_t claimant;

    // decode
    press_decode u_press_decode (
        .clk       (clk),
        .rst       (rst),
        .keypad_in (keypad_in),
        .new_round (new_round),
        .claim     (claim),
        .claimant  (claimant),
        .locked    (locked)
    );

    // execute
    score_update #(
        .score_w (score_w)
    ) u_score_update (
        .clk        (clk),
        .rst        (rst),
        .claim      (claim),
        .claimant   (claimant),
        .c1         (c1),
        .c2         (c2),
        .n1         (n1),
        .n2         (n2),
        .pile_count (pile_count),
        .score_a    (score_a),
        .score_b    (score_b)
    );

    // result
    win_judge #(
        .score_w    (score_w),
        .win_margin (win_margin)
    ) u_win_judge (
        .clk     (clk),
        .rst     (rst),
        .score_a (score_a),
        .score_b (score_b),
        .winner  (winner)
    );

endmodule

/* bell_pkg.sv */
package bell_pkg;

    // field widths
    localparam int key_w   = 4;
    localparam int color_w = 2;
    localparam int num_w   = 3;
    localparam int pile_w  = 8;

    // keypad codes of the two bell keys
    localparam logic [key_w-1:0] key_a = 4'd7;
    localparam logic [key_w-1:0] key_b = 4'd9;

    // the magic number of the game
    // same color: n1 + n2 must equal it
    // different color: one of the cards must show it
    localparam int unsigned bell_sum = 5;

    typedef enum logic [1:0] {
        player_none = 2'b00,
        player_a    = 2'b01,
        player_b    = 2'b10
    } player_t;

endpackage

/* press_decode.sv */
module press_decode import bell_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [key_w-1:0] keypad_in,
    input  logic             new_round,
    output logic             claim,
    output player_t          claimant,
    output logic             locked
);

    logic [key_w-1:0] key_q;    // sampled keypad code
    logic [key_w-1:0] key_prev; // code one cycle older
    player_t          key_player;
    player_t          prev_player;
    logic             fresh;
    logic             grant;

    function automatic player_t key_to_player(input logic [key_w-1:0] code);
        case (code)
            key_a:   return player_a;
            key_b:   return player_b;
            default: return player_none;
        endcase
    endfunction

    assign key_player  = key_to_player(key_q);
    assign prev_player = key_to_player(key_prev);

    // a player key right after a non-player code
    // so a held key only counts on its first cycle
    assign fresh = (key_player != player_none) && (prev_player == player_none);

    // new_round sampled with the key has already cleared the lock
    assign grant = fresh && !locked;

    always_ff @(posedge clk) begin
        if (!rst) begin
            key_q    <= '0;
            key_prev <= '0;
            claim    <= 1'b0;
            claimant <= player_none;
            locked   <= 1'b0;
        end else begin
            key_q    <= keypad_in;
            key_prev <= key_q;
            claim    <= grant;
            claimant <= grant ? key_player : player_none;
            if (grant) begin
                locked <= 1'b1; // rises together with claim
            end else if (new_round) begin
                locked <= 1'b0;
            end
        end
    end

    // one claim per press, never back to back
    a_claim_single: assert property (
        @(posedge clk) disable iff (!rst)
        claim |=> !claim
    );

    // a locked round stays locked until new cards arrive
    a_claim_unlocked: assert property (
        @(posedge clk) disable iff (!rst)
        $rose(claim) |-> (!$past(locked) || $past(new_round))
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the bell game testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_bell_game -f verilog.f -o sim_bell \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_bell > sim.log 2>&1 || echo "simulation ended with an error status"

grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* score_update.sv */
module score_update import bell_pkg::*; #(
    parameter int score_w = 10
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      claim,
    input  player_t                   claimant,
    input  logic [color_w-1:0]        c1,
    input  logic [color_w-1:0]        c2,
    input  logic [num_w-1:0]          n1,
    input  logic [num_w-1:0]          n2,
    input  logic [pile_w-1:0]         pile_count,
    output logic signed [score_w-1:0] score_a,
    output logic signed [score_w-1:0] score_b
);

    localparam logic signed [score_w-1:0] one = 1;

    logic [num_w:0]             num_sum;  // one extra bit, 7+7 must not wrap
    logic                       same_color;
    logic                       sum_hit;
    logic                       five_hit;
    logic                       hit;      // the bell was right
    logic signed [score_w-1:0]  pile_ext;

    assign num_sum    = n1 + n2;
    assign same_color = (c1 == c2);
    assign sum_hit    = (num_sum == (num_w+1)'(bell_sum));
    assign five_hit   = (n1 == num_w'(bell_sum)) || (n2 == num_w'(bell_sum));

    always_comb begin
        if (same_color) begin
            hit = sum_hit;
        end else begin
            hit = five_hit;
        end
    end

    // pile is unsigned, zero extend into the score width
    assign pile_ext = score_w'(pile_count);

    // scores wrap, the game never runs long enough to matter
    always_ff @(posedge clk) begin
        if (!rst) begin
            score_a <= '0;
            score_b <= '0;
        end else if (claim) begin
            case (claimant)
                player_a: begin
                    if (hit) begin
                        score_a <= score_a + pile_ext;
                    end else begin
                        score_a <= score_a - one;
                        score_b <= score_b + one; // penalty goes to the other side
                    end
                end
                player_b: begin
                    if (hit) begin
                        score_b <= score_b + pile_ext;
                    end else begin
                        score_b <= score_b - one;
                        score_a <= score_a + one;
                    end
                end
                default: begin
                    score_a <= score_a;
                    score_b <= score_b;
                end
            endcase
        end
    end

    // scores only move right after a claim
    a_score_after_claim: assert property (
        @(posedge clk) disable iff (!rst)
        ($changed(score_a) || $changed(score_b)) |-> $past(claim)
    );

endmodule

/* tb_bell_game.sv */
module tb_bell_game import bell_pkg::*; ();

    localparam int score_w    = 10;
    localparam int margin     = 50;
    localparam int n_random   = 300;
    localparam int n_directed = 24;
    localparam int round_max  = 40;   // cycles, longest round of any kind
    localparam int timeout    = (n_random + n_directed) * round_max * 4 + 400;
    localparam int score_lim  = 450;  // random presses stop beyond this
    localparam logic [key_w-1:0] idle_code = 4'd0;

    logic                      clk;
    logic                      rst;
    logic [key_w-1:0]          keypad_in;
    logic                      new_round;
    logic [color_w-1:0]        c1;
    logic [color_w-1:0]        c2;
    logic [num_w-1:0]          n1;
    logic [num_w-1:0]          n2;
    logic [pile_w-1:0]         pile_count;
    logic                      locked;
    logic signed [score_w-1:0] score_a;
    logic signed [score_w-1:0] score_b;
    player_t                   winner;

    logic [31:0] lcg_state;

    // reference model state
    logic [key_w-1:0] m_key_last;
    logic             m_fresh;      // player key after a non-player code
    logic             m_press;      // press sampled at the last edge that wins the round
    player_t          m_press_who;
    logic             m_claim;
    player_t          m_claim_who;
    logic             m_locked;
    int               m_score_a;
    int               m_score_b;
    player_t          m_winner;
    int               n_hit;
    int               n_miss;
    int               n_blocked;
    int               n_win_a;
    int               n_win_b;

    tb_clock #(.period(4)) u_clock (.clk(clk));

    bell_game_top dut (
        .clk        (clk),
        .rst        (rst),
        .keypad_in  (keypad_in),
        .new_round  (new_round),
        .c1         (c1),
        .c2         (c2),
        .n1         (n1),
        .n2         (n2),
        .pile_count (pile_count),
        .locked     (locked),
        .score_a    (score_a),
        .score_b    (score_b),
        .winner     (winner)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at time %0t", $time);
    endtask

    task automatic value_mismatch(input string name, input int got, input int exp);
        $display("ERR %s: got %h, expected %h", name, got, exp);
        fail_run("DUT output differs from the reference model");
    endtask

    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:16]) % n;
    endfunction

    function automatic logic is_player_key(input logic [key_w-1:0] code);
        return (code == key_a) || (code == key_b);
    endfunction

    function automatic player_t who_pressed(input logic [key_w-1:0] code);
        if (code == key_a) return player_a;
        if (code == key_b) return player_b;
        return player_none;
    endfunction

    // the bell rule on plain integers
    function automatic logic card_hit(input int ca, input int cb, input int na, input int nb);
        if (ca == cb) return (na + nb) == 5;
        return (na == 5) || (nb == 5);
    endfunction

    function automatic player_t lead_of(input int sa, input int sb);
        if (sa - sb > margin) return player_a;
        if (sb - sa > margin) return player_b;
        return player_none;
    endfunction

    assign m_fresh = is_player_key(keypad_in) && !is_player_key(m_key_last);

    always @(posedge clk) begin
        if (!rst) begin
            m_key_last  <= idle_code;
            m_press     <= 1'b0;
            m_press_who <= player_none;
            m_claim     <= 1'b0;
            m_claim_who <= player_none;
            m_locked    <= 1'b0;
            m_score_a   <= 0;
            m_score_b   <= 0;
            m_winner    <= player_none;
        end else begin
            m_key_last  <= keypad_in;
            // an open round, or new cards in the same cycle as the key
            m_press     <= m_fresh && (!m_locked || new_round);
            m_press_who <= who_pressed(keypad_in);
            m_claim     <= m_press;
            m_claim_who <= m_press_who;
            if (m_press) begin
                m_locked <= 1'b1; // together with the claim
            end else if (new_round) begin
                m_locked <= 1'b0;
            end
            if (m_fresh && m_locked && !new_round) n_blocked <= n_blocked + 1;
            if (m_claim) begin
                if (card_hit(int'(c1), int'(c2), int'(n1), int'(n2))) begin
                    n_hit <= n_hit + 1;
                    if (m_claim_who == player_a) m_score_a <= m_score_a + int'(pile_count);
                    else m_score_b <= m_score_b + int'(pile_count);
                end else begin
                    n_miss    <= n_miss + 1;
                    m_score_a <= (m_claim_who == player_a) ? m_score_a - 1 : m_score_a + 1;
                    m_score_b <= (m_claim_who == player_a) ? m_score_b + 1 : m_score_b - 1;
                end
            end
            m_winner <= lead_of(m_score_a, m_score_b); // sees the scores of the last edge
            if (m_winner == player_a) n_win_a <= n_win_a + 1;
            if (m_winner == player_b) n_win_b <= n_win_b + 1;
        end
    end

    chk_locked: assert property (@(posedge clk) disable iff (!rst) locked == m_locked)
        else value_mismatch("locked", int'($sampled(locked)), int'($sampled(m_locked)));

    chk_score_a: assert property (@(posedge clk) disable iff (!rst) int'(score_a) == m_score_a)
        else value_mismatch("score_a", int'($sampled(score_a)), $sampled(m_score_a));

    chk_score_b: assert property (@(posedge clk) disable iff (!rst) int'(score_b) == m_score_b)
        else value_mismatch("score_b", int'($sampled(score_b)), $sampled(m_score_b));

    chk_winner: assert property (@(posedge clk) disable iff (!rst) winner == m_winner)
        else value_mismatch("winner", int'($sampled(winner)), int'($sampled(m_winner)));

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic new_cards(input int ca, input int cb, input int na, input int nb,
                             input int pile);
        c1         = color_w'(ca);
        c2         = color_w'(cb);
        n1         = num_w'(na);
        n2         = num_w'(nb);
        pile_count = pile_w'(pile);
        new_round  = 1'b1;
        @(negedge clk);
        new_round  = 1'b0;
    endtask

    task automatic press_key(input logic [key_w-1:0] code, input int hold);
        keypad_in = code;
        repeat (hold) @(negedge clk);
        keypad_in = idle_code;
        @(negedge clk);
    endtask

    task automatic play(input int ca, input int cb, input int na, input int nb, input int pile,
                        input logic [key_w-1:0] code, input int hold);
        new_cards(ca, cb, na, nb, pile);
        press_key(code, hold);
        idle_cycles(5);
    endtask

    // correct claim that leaves the ringer exactly lead points ahead
    task automatic lead_by(input logic [key_w-1:0] code, input int lead);
        int pile;
        pile = (code == key_a) ? m_score_b - m_score_a + lead : m_score_a - m_score_b + lead;
        if (pile < 0 || pile > 255) fail_run("directed pile count does not fit the pile field");
        play(2, 2, 4, 1, pile, code, 2);
    endtask

    task automatic random_round();
        int               mode;
        logic [key_w-1:0] junk;
        mode = rand_below(8);
        new_cards(rand_below(4), rand_below(4), rand_below(8), rand_below(8), rand_below(8));
        if (rand_below(4) == 0) begin
            junk = key_w'(rand_below(16));
            if (is_player_key(junk)) junk = idle_code;
            keypad_in = junk;
            @(negedge clk);
            keypad_in = idle_code;
        end
        if (mode != 0 && m_score_a < score_lim && m_score_b < score_lim
                && m_score_a > -score_lim && m_score_b > -score_lim) begin
            repeat (rand_below(4)) @(negedge clk);
            press_key(rand_below(2) == 0 ? key_a : key_b, 1 + rand_below(6));
            if (mode > 5) begin  // late press into a locked round
                repeat (rand_below(3)) @(negedge clk);
                press_key(rand_below(2) == 0 ? key_a : key_b, 1 + rand_below(6));
            end
        end
        idle_cycles(5);
    endtask

    initial begin
        #(timeout);
        fail_run($sformatf("run timed out after %0d time units", timeout));
    end

    initial begin
        n_hit      = 0;
        n_miss     = 0;
        n_blocked  = 0;
        n_win_a    = 0;
        n_win_b    = 0;
        lcg_state  = 32'hb89e_b67a;
        rst        = 1'b0;
        keypad_in  = idle_code;
        new_round  = 1'b0;
        c1         = '0;
        c2         = '0;
        n1         = '0;
        n2         = '0;
        pile_count = '0;
        repeat (2) @(negedge clk);
        rst = 1'b1;
        idle_cycles(4);

        play(0, 0, 2, 3, 12, key_a, 1);  // same color, sum five
        play(1, 2, 5, 0, 9, key_b, 3);   // different color, a five
        play(2, 2, 5, 2, 20, key_a, 2);  // same color with a five is still wrong
        play(0, 3, 4, 6, 15, key_b, 1);
        play(3, 1, 2, 3, 7, key_a, 1);   // sum five but colors differ
        play(1, 1, 1, 1, 30, key_b, 2);

        // held key, then late presses by both players
        new_cards(3, 3, 4, 1, 5);
        press_key(key_a, 12);
        press_key(key_b, 2);
        press_key(key_a, 3);
        idle_cycles(3);
        // new cards and a press on the same edge while still locked
        keypad_in = key_b;
        new_cards(0, 1, 5, 5, 11);
        repeat (2) @(negedge clk);
        keypad_in = idle_code;
        idle_cycles(5);
        // locked press one cycle ahead of new cards, held across them
        keypad_in = key_a;
        @(negedge clk);
        new_cards(2, 1, 3, 5, 40);
        repeat (3) @(negedge clk);
        keypad_in = idle_code;
        idle_cycles(5);
        play(2, 2, 4, 1, 8, key_a, 1);

        play(0, 0, 0, 5, 60, key_a, 2);
        play(1, 1, 3, 2, 120, key_b, 2);
        lead_by(key_a, margin);      // exactly on the margin, no winner
        lead_by(key_a, margin + 1);
        lead_by(key_b, margin);
        lead_by(key_b, margin + 1);
        lead_by(key_a, 0);

        for (int i = 0; i < n_random; i++) begin
            random_round();
        end

        if (n_hit > 0 && n_miss > 0 && n_blocked > 0 && n_win_a > 0 && n_win_b > 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            fail_run("not every game situation was reached by the stimulus");
        end
    end

endmodule

/* tb_clock.sv */
module tb_clock #(
    parameter int period = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

/* verilog.f */
bell_pkg.sv
press_decode.sv
score_update.sv
win_judge.sv
bell_game_top.sv
tb_clock.sv
tb_bell_game.sv

/* win_judge.sv */
module win_judge import bell_pkg::*; #(
    parameter int score_w    = 10,
    parameter int win_margin = 50
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic signed [score_w-1:0] score_a,
    input  logic signed [score_w-1:0] score_b,
    output player_t                   winner
);

    // two guard bits, score plus margin cannot overflow
    localparam int ext_w = score_w + 2;
    localparam logic signed [ext_w-1:0] margin = ext_w'(win_margin);

    logic signed [ext_w-1:0] a_ext;
    logic signed [ext_w-1:0] b_ext;
    logic                    a_leads;
    logic                    b_leads;

    assign a_ext = score_a; // sign extended
    assign b_ext = score_b;

    assign a_leads = a_ext > (b_ext + margin);
    assign b_leads = b_ext > (a_ext + margin);

    always_ff @(posedge clk) begin
        if (!rst) begin
            winner <= player_none;
        end else if (a_leads) begin
            winner <= player_a;
        end else if (b_leads) begin
            winner <= player_b;
        end else begin
            winner <= player_none;
        end
    end

    a_winner_code: assert property (
        @(posedge clk) disable iff (!rst)
        winner inside {player_none, player_a, player_b}
    );

endmodule
